/* include/line_arb_macros.svh */
`ifndef LINE_ARB_MACROS_SVH
`define LINE_ARB_MACROS_SVH

// One cache line as moved between a requester and the arbiter
`define LINE_BITS 256

// One memory bus beat
`define BEAT_BITS 64

// Beats in one burst, so LINE_BITS / BEAT_BITS
`define BEATS_PER_LINE 4

// Outstanding read lines the arbiter can track
`define PEND_DEPTH 4

`endif

/* hdl/line_arb_pkg.sv */
`include "line_arb_macros.svh"

package line_arb_pkg;

    typedef logic [31:0] line_addr_t;
    typedef logic [`LINE_BITS-1:0] line_data_t;
    typedef logic [`BEAT_BITS-1:0] beat_data_t;
    typedef logic [$clog2(`BEATS_PER_LINE)-1:0] beat_idx_t;

    // Owner of a request
    typedef logic src_t;
    localparam src_t SRC_INST = 1'b0;
    localparam src_t SRC_DATA = 1'b1;

    typedef struct packed {
        line_addr_t addr;
        logic       write;
        line_data_t wdata;
    } line_req_t;

    typedef struct packed {
        line_addr_t addr;
        logic       write;
        beat_data_t wdata;
    } mem_cmd_t;

    // Returned beat, tagged with the line it belongs to
    typedef struct packed {
        line_addr_t addr;
        beat_data_t data;
    } mem_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_CMD,
        WRITE_BURST
    } arb_state_t;

endpackage

/* hdl/beat_counter.sv */
`timescale 1ns/1ps

`include "line_arb_macros.svh"

module beat_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    adv,
    output line_arb_pkg::beat_idx_t count,
    output logic                    last
);
    import line_arb_pkg::*;

    localparam beat_idx_t LAST_IDX = beat_idx_t'(`BEATS_PER_LINE - 1);

    assign last = (count == LAST_IDX);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (adv) begin
            // Wrap after the final beat so the next burst starts at zero
            if (last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* hdl/arb_fsm.sv */
`timescale 1ns/1ps

module arb_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               ireq_valid,
    input  logic               dreq_valid,
    input  logic               dreq_write,
    input  logic               table_full,
    input  logic               mem_cmd_ready,
    input  logic               last_beat,
    output logic               ireq_ready,
    output logic               dreq_ready,
    output logic               mem_cmd_valid,
    output logic               cmd_is_write,
    output line_arb_pkg::src_t cmd_src,
    output logic               alloc,
    output logic               load_wr,
    output logic               beat_adv,
    output logic               wr_done
);
    import line_arb_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    src_t       owner_q;
    src_t       grant_src;
    logic       grant_d;
    logic       grant_i;
    logic       accept;

    // Data side first; a writeback needs no table slot
    assign grant_d = dreq_valid && (dreq_write || !table_full);
    assign grant_i = !grant_d && ireq_valid && !table_full;
    assign grant_src = grant_d ? SRC_DATA : SRC_INST;

    assign dreq_ready = (state == IDLE) && grant_d;
    assign ireq_ready = (state == IDLE) && grant_i;
    assign accept = dreq_ready || ireq_ready;

    assign load_wr = dreq_ready && dreq_write;
    assign alloc = accept && !load_wr;

    assign mem_cmd_valid = (state != IDLE);
    assign cmd_is_write = (state == WRITE_BURST);
    assign beat_adv = cmd_is_write && mem_cmd_ready;

    // Live grant while idle, latched owner while a command is out
    assign cmd_src = (state == IDLE) ? grant_src : owner_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (load_wr) begin
                    state_next = WRITE_BURST;
                end else if (accept) begin
                    state_next = READ_CMD;
                end
            end
            READ_CMD: begin
                if (mem_cmd_ready) begin
                    state_next = IDLE;
                end
            end
            WRITE_BURST: begin
                if (mem_cmd_ready && last_beat) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            owner_q <= SRC_INST;
            wr_done <= 1'b0;
        end else begin
            state   <= state_next;
            wr_done <= beat_adv && last_beat;
            if (accept) begin
                owner_q <= grant_src;
            end
        end
    end

endmodule

/* hdl/write_burst_serializer.sv */
`timescale 1ns/1ps

`include "line_arb_macros.svh"

module write_burst_serializer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  line_arb_pkg::line_data_t wr_line,
    input  line_arb_pkg::line_addr_t wr_addr,
    input  logic                     beat_adv,
    output line_arb_pkg::beat_data_t beat,
    output line_arb_pkg::line_addr_t addr,
    output logic                     last_beat
);
    import line_arb_pkg::*;

    line_data_t line_q;
    line_addr_t addr_q;
    beat_idx_t  beat_idx;
    logic       cnt_last;

    beat_counter u_beat_cnt (
        .clk   (clk),
        .rst   (rst),
        .adv   (beat_adv),
        .count (beat_idx),
        .last  (cnt_last)
    );

    // Line and address held for the whole burst
    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= wr_line;
            addr_q <= wr_addr;
        end
    end

    // Lowest beat goes out first
    assign beat = line_q[beat_idx * `BEAT_BITS +: `BEAT_BITS];
    assign addr = addr_q;
    assign last_beat = cnt_last;

endmodule

/* hdl/read_line_assembler.sv */
`timescale 1ns/1ps

`include "line_arb_macros.svh"

module read_line_assembler (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rvalid,
    input  line_arb_pkg::mem_beat_t  rbeat,
    output logic                     line_valid,
    output line_arb_pkg::line_data_t line,
    output line_arb_pkg::line_addr_t line_addr
);
    import line_arb_pkg::*;

    // Only the first beats need a buffer, the last one goes straight into the line
    beat_data_t beat_buf [`BEATS_PER_LINE-1];
    beat_idx_t  beat_idx;
    logic       last;
    line_data_t full_line;

    beat_counter u_beat_cnt (
        .clk   (clk),
        .rst   (rst),
        .adv   (rvalid),
        .count (beat_idx),
        .last  (last)
    );

    always_comb begin
        full_line = '0;
        for (int i = 0; i < `BEATS_PER_LINE - 1; i++) begin
            full_line[i*`BEAT_BITS +: `BEAT_BITS] = beat_buf[i];
        end
        full_line[(`BEATS_PER_LINE-1)*`BEAT_BITS +: `BEAT_BITS] = rbeat.data;
    end

    always_ff @(posedge clk) begin
        if (rvalid && !last) begin
            beat_buf[beat_idx] <= rbeat.data;
        end
        if (rvalid && last) begin
            line      <= full_line;
            line_addr <= rbeat.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= rvalid && last;
        end
    end

endmodule

/* hdl/pending_table.sv */
`timescale 1ns/1ps

`include "line_arb_macros.svh"

module pending_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc,
    input  line_arb_pkg::line_addr_t alloc_addr,
    input  line_arb_pkg::src_t       alloc_src,
    input  logic                     line_valid,
    input  line_arb_pkg::line_addr_t line_addr,
    input  line_arb_pkg::line_data_t line,
    output logic                     full,
    output logic                     iresp_valid,
    output line_arb_pkg::line_data_t iresp_line,
    output logic                     dresp_rd_valid,
    output line_arb_pkg::line_data_t dresp_line
);
    import line_arb_pkg::*;

    localparam int IDX_W = $clog2(`PEND_DEPTH);

    logic       ent_valid [`PEND_DEPTH];
    line_addr_t ent_addr  [`PEND_DEPTH];
    src_t       ent_src   [`PEND_DEPTH];

    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             hit;
    logic [IDX_W-1:0] hit_idx;

    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        hit        = 1'b0;
        hit_idx    = '0;
        full       = 1'b1;
        // Scan from the top down so the lowest free slot wins
        for (int i = `PEND_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
                full       = 1'b0;
            end
            if (ent_valid[i] && ent_addr[i] == line_addr) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    // A finished line goes only to the requester that asked for it
    assign iresp_valid    = line_valid && hit && (ent_src[hit_idx] == SRC_INST);
    assign dresp_rd_valid = line_valid && hit && (ent_src[hit_idx] == SRC_DATA);
    assign iresp_line     = line;
    assign dresp_line     = line;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PEND_DEPTH; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else begin
            if (line_valid && hit) begin
                ent_valid[hit_idx] <= 1'b0;
            end
            if (alloc && free_found) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && free_found) begin
            ent_addr[free_idx] <= alloc_addr;
            ent_src[free_idx]  <= alloc_src;
        end
    end

endmodule

/* hdl/line_mem_arbiter.sv */
`timescale 1ns/1ps

module line_mem_arbiter (
    input  logic                     clk,
    input  logic                     rst,

    // Instruction side, reads only
    input  logic                     ireq_valid,
    output logic                     ireq_ready,
    input  line_arb_pkg::line_addr_t ireq_addr,
    output logic                     iresp_valid,
    output line_arb_pkg::line_data_t iresp_line,

    // Data side, reads and writebacks
    input  logic                     dreq_valid,
    output logic                     dreq_ready,
    input  line_arb_pkg::line_req_t  dreq,
    output logic                     dresp_valid,
    output line_arb_pkg::line_data_t dresp_line,

    // Banked memory
    output logic                     mem_cmd_valid,
    input  logic                     mem_cmd_ready,
    output line_arb_pkg::mem_cmd_t   mem_cmd,
    input  logic                     mem_rvalid,
    input  line_arb_pkg::mem_beat_t  mem_rbeat
);
    import line_arb_pkg::*;

    logic       table_full;
    logic       last_beat;
    logic       cmd_is_write;
    src_t       cmd_src;
    logic       alloc;
    logic       load_wr;
    logic       beat_adv;
    logic       wr_done;
    line_addr_t grant_addr;
    beat_data_t ser_beat;
    line_addr_t ser_addr;
    logic       line_valid;
    line_data_t asm_line;
    line_addr_t asm_addr;
    logic       dresp_rd_valid;

    arb_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .ireq_valid    (ireq_valid),
        .dreq_valid    (dreq_valid),
        .dreq_write    (dreq.write),
        .table_full    (table_full),
        .mem_cmd_ready (mem_cmd_ready),
        .last_beat     (last_beat),
        .ireq_ready    (ireq_ready),
        .dreq_ready    (dreq_ready),
        .mem_cmd_valid (mem_cmd_valid),
        .cmd_is_write  (cmd_is_write),
        .cmd_src       (cmd_src),
        .alloc         (alloc),
        .load_wr       (load_wr),
        .beat_adv      (beat_adv),
        .wr_done       (wr_done)
    );

    assign grant_addr = (cmd_src == SRC_DATA) ? dreq.addr : ireq_addr;

    // Also latches the address of a read so the command survives the requester moving on
    write_burst_serializer u_wr_ser (
        .clk       (clk),
        .rst       (rst),
        .load      (load_wr || alloc),
        .wr_line   (dreq.wdata),
        .wr_addr   (grant_addr),
        .beat_adv  (beat_adv),
        .beat      (ser_beat),
        .addr      (ser_addr),
        .last_beat (last_beat)
    );

    read_line_assembler u_rd_asm (
        .clk        (clk),
        .rst        (rst),
        .rvalid     (mem_rvalid),
        .rbeat      (mem_rbeat),
        .line_valid (line_valid),
        .line       (asm_line),
        .line_addr  (asm_addr)
    );

    pending_table u_pend (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .alloc_addr     (grant_addr),
        .alloc_src      (cmd_src),
        .line_valid     (line_valid),
        .line_addr      (asm_addr),
        .line           (asm_line),
        .full           (table_full),
        .iresp_valid    (iresp_valid),
        .iresp_line     (iresp_line),
        .dresp_rd_valid (dresp_rd_valid),
        .dresp_line     (dresp_line)
    );

    assign mem_cmd.addr  = ser_addr;
    assign mem_cmd.write = cmd_is_write;
    assign mem_cmd.wdata = ser_beat;

    // Write completion and read data share the data response
    assign dresp_valid = wr_done || dresp_rd_valid;

endmodule

/* tests/line_mem_arbiter_properties.sv */
`timescale 1ns/1ps

module line_mem_arbiter_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   ireq_ready,
    input logic                   dreq_ready,
    input logic                   mem_cmd_valid,
    input logic                   mem_cmd_ready,
    input line_arb_pkg::mem_cmd_t mem_cmd
);

    // Command held until the memory takes it
    cmd_stable: assert property (
        @(posedge clk) disable iff (rst)
        mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd)
    ) else $error("memory command changed before it was accepted");

    one_ready: assert property (
        @(posedge clk) disable iff (rst)
        !(ireq_ready && dreq_ready)
    ) else $error("both requesters granted in one cycle");

    // No new grant during a writeback burst
    no_ready_in_write: assert property (
        @(posedge clk) disable iff (rst)
        mem_cmd_valid && mem_cmd.write |-> !ireq_ready && !dreq_ready
    ) else $error("requester granted while a write burst runs");

endmodule

bind line_mem_arbiter line_mem_arbiter_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .ireq_ready    (ireq_ready),
    .dreq_ready    (dreq_ready),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd       (mem_cmd)
);

/* tests/line_mem_arbiter_tb.sv */
`timescale 1ns/1ps

`include "line_arb_macros.svh"

module line_mem_arbiter_tb;
    import line_arb_pkg::*;

    typedef logic [`LINE_BITS-1:0] chk_t;

    // Longest test runs a few hundred cycles, stalls included
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] SEED = 32'hef6d069b;
    localparam line_data_t WR_LINE_A = {64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
                                        64'h0f1e_2d3c_4b5a_6978, 64'h8796_a5b4_c3d2_e1f0};
    localparam line_data_t WR_LINE_B = {64'h1122_3344_5566_7788, 64'h99aa_bbcc_ddee_ff00,
                                        64'hdead_beef_cafe_f00d, 64'h0bad_c0de_5eed_1234};

    logic       clk = 1'b0;
    logic       rst;
    logic       ireq_valid;
    logic       ireq_ready;
    line_addr_t ireq_addr;
    logic       iresp_valid;
    line_data_t iresp_line;
    logic       dreq_valid;
    logic       dreq_ready;
    line_req_t  dreq;
    logic       dresp_valid;
    line_data_t dresp_line;
    logic       mem_cmd_valid;
    logic       mem_cmd_ready;
    mem_cmd_t   mem_cmd;
    logic       mem_rvalid;
    mem_beat_t  mem_rbeat;

    // Memory model state and logs
    line_data_t mem_lines [line_addr_t];
    line_addr_t rd_q[$];
    mem_cmd_t   cmd_log[$];
    line_data_t i_resp_q[$];
    line_data_t d_resp_q[$];
    logic       stall_en = 1'b0;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    line_mem_arbiter uut (
        .clk           (clk),
        .rst           (rst),
        .ireq_valid    (ireq_valid),
        .ireq_ready    (ireq_ready),
        .ireq_addr     (ireq_addr),
        .iresp_valid   (iresp_valid),
        .iresp_line    (iresp_line),
        .dreq_valid    (dreq_valid),
        .dreq_ready    (dreq_ready),
        .dreq          (dreq),
        .dresp_valid   (dresp_valid),
        .dresp_line    (dresp_line),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd       (mem_cmd),
        .mem_rvalid    (mem_rvalid),
        .mem_rbeat     (mem_rbeat)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles, %0d errors so far",
                     TIMEOUT_CYCLES, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Unwritten lines read back a pattern built from the full address
    function automatic line_data_t model_line(line_addr_t a);
        line_data_t l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int i = 0; i < `BEATS_PER_LINE; i++) begin
            l[i*`BEAT_BITS +: `BEAT_BITS] = {a ^ (32'h9e37_79b9 * 32'(i + 1)), a + 32'(i)};
        end
        return l;
    endfunction

    // Memory command side, commands are taken just before the rising edge
    initial begin : mem_model
        line_data_t wr_buf;
        int         wr_cnt;
        void'($urandom(SEED));
        mem_cmd_ready = 1'b0;
        wr_cnt = 0;
        forever begin
            @(negedge clk);
            if (stall_en) begin
                mem_cmd_ready = ($urandom_range(3) != 0);
            end else begin
                mem_cmd_ready = 1'b1;
            end
            #1;
            if (mem_cmd_valid && mem_cmd_ready) begin
                cmd_log.push_back(mem_cmd);
                if (mem_cmd.write) begin
                    wr_buf[wr_cnt*`BEAT_BITS +: `BEAT_BITS] = mem_cmd.wdata;
                    if (wr_cnt == `BEATS_PER_LINE - 1) begin
                        mem_lines[mem_cmd.addr] = wr_buf;
                        wr_cnt = 0;
                    end else begin
                        wr_cnt++;
                    end
                end else begin
                    rd_q.push_back(mem_cmd.addr);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (iresp_valid) begin
            i_resp_q.push_back(iresp_line);
        end
        if (dresp_valid) begin
            d_resp_q.push_back(dresp_line);
        end
    end

    task automatic check(string name, chk_t got, chk_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic clear_logs();
        rd_q.delete();
        cmd_log.delete();
        i_resp_q.delete();
        d_resp_q.delete();
    endtask

    task automatic send_iread(line_addr_t a);
        @(negedge clk);
        ireq_valid = 1'b1;
        ireq_addr = a;
        #1;
        while (!ireq_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ireq_valid = 1'b0;
    endtask

    task automatic send_dreq(line_addr_t a, logic wr, line_data_t data);
        @(negedge clk);
        dreq_valid = 1'b1;
        dreq.addr = a;
        dreq.write = wr;
        dreq.wdata = data;
        #1;
        while (!dreq_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        dreq_valid = 1'b0;
    endtask

    task automatic wait_reads(int n);
        while (rd_q.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_responses(int n_i, int n_d);
        while (i_resp_q.size() < n_i || d_resp_q.size() < n_d) begin
            @(posedge clk);
        end
    endtask

    // Four contiguous beats tagged with the line address
    task automatic return_burst(line_addr_t a);
        line_data_t l;
        l = model_line(a);
        for (int i = 0; i < `BEATS_PER_LINE; i++) begin
            @(negedge clk);
            mem_rvalid = 1'b1;
            mem_rbeat.addr = a;
            mem_rbeat.data = l[i*`BEAT_BITS +: `BEAT_BITS];
        end
        @(negedge clk);
        mem_rvalid = 1'b0;
    endtask

    task automatic reset_state();
        #1;
        check("ireq_ready", chk_t'(ireq_ready), chk_t'(0));
        check("dreq_ready", chk_t'(dreq_ready), chk_t'(0));
        check("mem_cmd_valid", chk_t'(mem_cmd_valid), chk_t'(0));
        check("iresp_valid", chk_t'(iresp_valid), chk_t'(0));
        check("dresp_valid", chk_t'(dresp_valid), chk_t'(0));
    endtask

    task automatic inst_read(line_addr_t a);
        clear_logs();
        send_iread(a);
        wait_reads(1);
        check("read mem_cmd.addr", chk_t'(rd_q.pop_front()), chk_t'(a));
        return_burst(a);
        wait_responses(1, 0);
        repeat (2) @(posedge clk);
        check("iresp_line", i_resp_q[0], model_line(a));
        check("dresp_valid count", chk_t'(d_resp_q.size()), chk_t'(0));
    endtask

    task automatic data_writeback(line_addr_t a, line_data_t data);
        clear_logs();
        send_dreq(a, 1'b1, data);
        wait_responses(0, 1);
        check("write beat count", chk_t'(cmd_log.size()), chk_t'(`BEATS_PER_LINE));
        for (int i = 0; i < cmd_log.size(); i++) begin
            check("mem_cmd.addr", chk_t'(cmd_log[i].addr), chk_t'(a));
            check("mem_cmd.write", chk_t'(cmd_log[i].write), chk_t'(1));
            check("mem_cmd.wdata", chk_t'(cmd_log[i].wdata),
                  chk_t'(data[i*`BEAT_BITS +: `BEAT_BITS]));
        end
        // Read the line back through the data side
        send_dreq(a, 1'b0, '0);
        wait_reads(1);
        check("read mem_cmd.addr", chk_t'(rd_q.pop_front()), chk_t'(a));
        return_burst(a);
        wait_responses(0, 2);
        check("dresp_line", d_resp_q[1], data);
    endtask

    task automatic arbitration();
        clear_logs();
        fork
            send_iread(32'h0000_3020);
            send_dreq(32'h0000_3000, 1'b0, '0);
        join
        wait_reads(2);
        check("first mem_cmd.addr", chk_t'(cmd_log[0].addr), chk_t'(32'h0000_3000));
        check("second mem_cmd.addr", chk_t'(cmd_log[1].addr), chk_t'(32'h0000_3020));
        return_burst(32'h0000_3000);
        return_burst(32'h0000_3020);
        wait_responses(1, 1);
        check("dresp_line", d_resp_q[0], model_line(32'h0000_3000));
        check("iresp_line", i_resp_q[0], model_line(32'h0000_3020));
    endtask

    task automatic out_of_order_routing();
        line_addr_t addrs [4];
        addrs = '{32'h0000_6000, 32'h0000_6020, 32'h0000_6040, 32'h0000_6060};
        clear_logs();
        send_iread(addrs[0]);
        send_dreq(addrs[1], 1'b0, '0);
        send_iread(addrs[2]);
        send_dreq(addrs[3], 1'b0, '0);
        wait_reads(4);
        for (int i = 0; i < 4; i++) begin
            check("read mem_cmd.addr", chk_t'(rd_q[i]), chk_t'(addrs[i]));
        end
        // Table is full, neither side may be granted
        @(negedge clk);
        ireq_valid = 1'b1;
        ireq_addr = 32'h0000_7000;
        dreq_valid = 1'b1;
        dreq.addr = 32'h0000_7020;
        dreq.write = 1'b0;
        repeat (3) begin
            #1;
            check("ireq_ready", chk_t'(ireq_ready), chk_t'(0));
            check("dreq_ready", chk_t'(dreq_ready), chk_t'(0));
            @(negedge clk);
        end
        ireq_valid = 1'b0;
        dreq_valid = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            return_burst(addrs[i]);
        end
        wait_responses(2, 2);
        check("dresp_line", d_resp_q[0], model_line(addrs[3]));
        check("iresp_line", i_resp_q[0], model_line(addrs[2]));
        check("dresp_line", d_resp_q[1], model_line(addrs[1]));
        check("iresp_line", i_resp_q[1], model_line(addrs[0]));
    endtask

    initial begin
        rst = 1'b1;
        ireq_valid = 1'b0;
        ireq_addr = '0;
        dreq_valid = 1'b0;
        dreq = '0;
        mem_rvalid = 1'b0;
        mem_rbeat = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state();
        inst_read(32'h0000_1000);
        data_writeback(32'h0000_2040, WR_LINE_A);
        arbitration();
        out_of_order_routing();

        // Same traffic with the memory stalling commands
        @(posedge clk);
        stall_en = 1'b1;
        inst_read(32'h0004_0100);
        data_writeback(32'h0005_0180, WR_LINE_B);

        repeat (4) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hdl/line_arb_pkg.sv
hdl/beat_counter.sv
hdl/arb_fsm.sv
hdl/write_burst_serializer.sv
hdl/read_line_assembler.sv
hdl/pending_table.sv
hdl/line_mem_arbiter.sv
tests/line_mem_arbiter_properties.sv
tests/line_mem_arbiter_tb.sv

/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vline_mem_arbiter_tb: all.f $(wildcard hdl/*.sv tests/*.sv include/*.svh)
	verilator --binary --timing --assert -f all.f --top-module line_mem_arbiter_tb

run: obj_dir/Vline_mem_arbiter_tb
	./obj_dir/Vline_mem_arbiter_tb > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -f all.f --top-module line_mem_arbiter_tb

clean:
	rm -rf obj_dir sim.log
